// ==== Bender.yml ====
package:
  name: riscv151

sources:
  - design/riscv151_pkg.sv
  - design/imem_loader.sv
  - design/decoder.sv
  - design/regfile.sv
  - design/alu.sv
  - design/pipeline.sv
  - design/riscv151_top.sv
  - target: test
    files:
      - testbench/riscv151_props.sv
      - testbench/tb_riscv151.sv

// ==== design/alu.sv ====
module alu (
    input  riscv151_pkg::word_t   a_i,
    input  riscv151_pkg::word_t   b_i,
    input  riscv151_pkg::alu_op_e op_i,
    input  riscv151_pkg::br_op_e  br_i,
    output riscv151_pkg::word_t   result_o,
    output logic                  taken_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0]; // rv32 shifts use low five bits

    always_comb begin
        unique case (op_i)
            riscv151_pkg::ALU_ADD:    result_o = a_i + b_i;
            riscv151_pkg::ALU_SUB:    result_o = a_i - b_i;
            riscv151_pkg::ALU_SLL:    result_o = a_i << shamt;
            riscv151_pkg::ALU_SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            riscv151_pkg::ALU_SLTU:   result_o = {31'b0, a_i < b_i};
            riscv151_pkg::ALU_XOR:    result_o = a_i ^ b_i;
            riscv151_pkg::ALU_SRL:    result_o = a_i >> shamt;
            riscv151_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;
            riscv151_pkg::ALU_OR:     result_o = a_i | b_i;
            riscv151_pkg::ALU_AND:    result_o = a_i & b_i;
            riscv151_pkg::ALU_PASS_B: result_o = b_i; // lui
            default:                  result_o = '0;
        endcase
    end

    // branch comparator on the same operands
    always_comb begin
        case (br_i)
            riscv151_pkg::BR_EQ: taken_o = (a_i == b_i);
            riscv151_pkg::BR_NE: taken_o = (a_i != b_i);
            riscv151_pkg::BR_LT: taken_o = ($signed(a_i) <  $signed(b_i));
            riscv151_pkg::BR_GE: taken_o = ($signed(a_i) >= $signed(b_i));
            default:             taken_o = 1'b0;
        endcase
    end

endmodule

// ==== design/decoder.sv ====
module decoder (
    input  riscv151_pkg::word_t inst_i,
    output riscv151_pkg::ctrl_t ctrl_o
);

    riscv151_pkg::opcode_e opcode;
    riscv151_pkg::alu_op_e arith_op; // shared by reg and imm forms
    riscv151_pkg::word_t   imm_i, imm_b, imm_u, imm_j;
    logic [2:0]            funct3;
    logic                  alt;      // bit 30 selects sub / sra

    assign opcode = riscv151_pkg::opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign alt    = inst_i[30];

    // immediate formats
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // alu control from funct3 and bit 30
    always_comb begin
        unique case (funct3)
            3'b000: arith_op = (alt && opcode == riscv151_pkg::OP_REG) ?
                               riscv151_pkg::ALU_SUB : riscv151_pkg::ALU_ADD; // addi has no sub
            3'b001: arith_op = riscv151_pkg::ALU_SLL;
            3'b010: arith_op = riscv151_pkg::ALU_SLT;
            3'b011: arith_op = riscv151_pkg::ALU_SLTU;
            3'b100: arith_op = riscv151_pkg::ALU_XOR;
            3'b101: arith_op = alt ? riscv151_pkg::ALU_SRA : riscv151_pkg::ALU_SRL;
            3'b110: arith_op = riscv151_pkg::ALU_OR;
            default: arith_op = riscv151_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_o        = '0; // nop that writes nothing
        ctrl_o.rs1    = inst_i[19:15];
        ctrl_o.rs2    = inst_i[24:20];
        case (opcode)
            riscv151_pkg::OP_REG: begin
                ctrl_o.alu_op = arith_op;
                ctrl_o.reg_we = 1'b1;
                ctrl_o.rd     = inst_i[11:7];
            end
            riscv151_pkg::OP_IMM: begin
                ctrl_o.alu_op  = arith_op;
                ctrl_o.use_imm = 1'b1;
                ctrl_o.imm     = imm_i;
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.rd      = inst_i[11:7];
            end
            riscv151_pkg::OP_LUI: begin
                ctrl_o.alu_op  = riscv151_pkg::ALU_PASS_B; // imm straight through
                ctrl_o.use_imm = 1'b1;
                ctrl_o.imm     = imm_u;
                ctrl_o.reg_we  = 1'b1;
                ctrl_o.rd      = inst_i[11:7];
            end
            riscv151_pkg::OP_BRANCH: begin
                ctrl_o.imm = imm_b;
                case (funct3)
                    3'b000:  ctrl_o.br_op = riscv151_pkg::BR_EQ;
                    3'b001:  ctrl_o.br_op = riscv151_pkg::BR_NE;
                    3'b100:  ctrl_o.br_op = riscv151_pkg::BR_LT;
                    3'b101:  ctrl_o.br_op = riscv151_pkg::BR_GE;
                    default: ctrl_o.br_op = riscv151_pkg::BR_NONE; // unsigned forms fall through
                endcase
            end
            riscv151_pkg::OP_JAL: begin
                ctrl_o.jump   = 1'b1;
                ctrl_o.imm    = imm_j;
                ctrl_o.wb_sel = riscv151_pkg::WB_PC4;
                ctrl_o.reg_we = 1'b1;
                ctrl_o.rd     = inst_i[11:7];
            end
            default: ;
        endcase
    end

endmodule

// ==== design/imem_loader.sv ====
module imem_loader #(
    parameter int IMEM_AWIDTH = 8
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           prog_req_i,
    input  riscv151_pkg::prog_wr_t         prog_i,
    input  logic [IMEM_AWIDTH-1:0]         fetch_addr_i,
    output logic                           prog_ack_o,
    output riscv151_pkg::word_t            fetch_data_o
);

    localparam int DEPTH = 2 ** IMEM_AWIDTH;

    riscv151_pkg::word_t mem [DEPTH];

    logic ack_q;
    logic do_write; // first edge of a new request

    assign do_write   = prog_req_i & ~ack_q;
    assign prog_ack_o = ack_q;

    // four-phase slave
    // ack follows req one clock later, so it rises after the write
    // and falls on the clock after req is seen low
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= prog_req_i;
        end
    end

    // host write port
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[prog_i.addr[IMEM_AWIDTH-1:0]] <= prog_i.data;
        end
    end

    // fetch port, one cycle latency
    always_ff @(posedge clk) begin
        fetch_data_o <= mem[fetch_addr_i];
    end

endmodule

// ==== design/pipeline.sv ====
module pipeline #(
    parameter riscv151_pkg::word_t RESET_PC    = '0,
    parameter int                  IMEM_AWIDTH = 8
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     core_en_i,
    input  riscv151_pkg::word_t      fetch_data_i,
    input  riscv151_pkg::ctrl_t      ctrl_i,
    input  riscv151_pkg::word_t      rdata1_i,
    input  riscv151_pkg::word_t      rdata2_i,
    input  riscv151_pkg::word_t      alu_result_i,
    input  logic                     alu_taken_i,
    output logic [IMEM_AWIDTH-1:0]   fetch_addr_o,
    output riscv151_pkg::word_t      inst_o,
    output riscv151_pkg::reg_addr_t  rs1_o,
    output riscv151_pkg::reg_addr_t  rs2_o,
    output riscv151_pkg::word_t      alu_a_o,
    output riscv151_pkg::word_t      alu_b_o,
    output riscv151_pkg::alu_op_e    alu_op_o,
    output riscv151_pkg::br_op_e     br_op_o,
    output logic                     rf_we_o,
    output riscv151_pkg::reg_addr_t  rf_waddr_o,
    output riscv151_pkg::word_t      rf_wdata_o,
    output logic                     retire_valid_o,
    output riscv151_pkg::retire_t    retire_o
);

    riscv151_pkg::word_t pc_q;       // address being fetched
    riscv151_pkg::word_t fpc_q;      // pc of the word on fetch_data_i
    logic                fv_q;       // fetch register valid
    riscv151_pkg::word_t wb_data_q, wb_pc_q;
    riscv151_pkg::reg_addr_t wb_rd_q;
    logic                wb_we_q, wb_valid_q;

    riscv151_pkg::word_t op1, op2;   // forwarded sources
    riscv151_pkg::word_t target, ex_wdata;
    logic                fwd1, fwd2, redirect;

    // fetch, memory output acts as the fetch register
    assign fetch_addr_o = pc_q[IMEM_AWIDTH+1:2]; // word index
    assign inst_o       = fetch_data_i;

    // execute operands
    assign rs1_o = ctrl_i.rs1;
    assign rs2_o = ctrl_i.rs2;
    assign fwd1  = rf_we_o && wb_rd_q != '0 && wb_rd_q == ctrl_i.rs1; // wb -> ex bypass
    assign fwd2  = rf_we_o && wb_rd_q != '0 && wb_rd_q == ctrl_i.rs2;
    assign op1   = fwd1 ? wb_data_q : rdata1_i;
    assign op2   = fwd2 ? wb_data_q : rdata2_i;

    assign alu_a_o  = op1;
    assign alu_b_o  = ctrl_i.use_imm ? ctrl_i.imm : op2;
    assign alu_op_o = ctrl_i.alu_op;
    assign br_op_o  = ctrl_i.br_op;

    // branch / jal target and redirect
    assign target   = fpc_q + ctrl_i.imm;
    assign redirect = fv_q & (ctrl_i.jump | alu_taken_i);
    assign ex_wdata = (ctrl_i.wb_sel == riscv151_pkg::WB_PC4) ? fpc_q + 32'd4 : alu_result_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            fv_q       <= 1'b0;
            wb_valid_q <= 1'b0;
        end else if (!core_en_i) begin   // idle, hold at reset pc
            pc_q       <= RESET_PC;
            fv_q       <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            pc_q       <= redirect ? target : pc_q + 32'd4;
            fv_q       <= ~redirect;      // squash the word behind a taken jump
            wb_valid_q <= fv_q;
        end
    end

    // payload, qualified by the valid bits above
    always_ff @(posedge clk) begin
        fpc_q     <= pc_q;
        wb_data_q <= ex_wdata;
        wb_rd_q   <= ctrl_i.rd;
        wb_we_q   <= ctrl_i.reg_we;
        wb_pc_q   <= fpc_q;
    end

    // write-back
    assign rf_we_o    = wb_valid_q & wb_we_q;
    assign rf_waddr_o = wb_rd_q;
    assign rf_wdata_o = wb_data_q;

    // retire trace, data zero when nothing lands in a register
    assign retire_valid_o = wb_valid_q;
    assign retire_o.pc    = wb_pc_q;
    assign retire_o.rd    = wb_rd_q;
    assign retire_o.data  = (wb_we_q && wb_rd_q != '0) ? wb_data_q : '0;

endmodule

// ==== design/regfile.sv ====
module regfile (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   we_i,
    input  riscv151_pkg::reg_addr_t waddr_i,
    input  riscv151_pkg::word_t     wdata_i,
    input  riscv151_pkg::reg_addr_t raddr1_i,
    input  riscv151_pkg::reg_addr_t raddr2_i,
    output riscv151_pkg::word_t     rdata1_o,
    output riscv151_pkg::word_t     rdata2_o
);

    riscv151_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0; // architectural state starts clean
        end else if (we_i && waddr_i != '0) begin         // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // async reads
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== design/riscv151_pkg.sv ====
package riscv151_pkg;

    typedef logic [31:0] word_t;     // data, instruction or pc
    typedef logic [4:0]  reg_addr_t; // architectural register index

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE
    } br_op_e;

    typedef enum logic {
        WB_ALU, // alu result
        WB_PC4  // link address for jal
    } wb_sel_e;

    // decode result consumed by execute
    typedef struct packed {
        alu_op_e   alu_op;
        br_op_e    br_op;
        logic      jump;
        logic      use_imm;  // b operand from immediate
        logic      reg_we;
        wb_sel_e   wb_sel;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;       // zero for non-writers
        word_t     imm;
    } ctrl_t;

    typedef struct packed {
        word_t addr; // word index, low bits used
        word_t data;
    } prog_wr_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

// ==== design/riscv151_top.sv ====
module riscv151_top #(
    parameter riscv151_pkg::word_t RESET_PC    = '0,
    parameter int                  IMEM_AWIDTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   core_en_i,
    input  logic                   prog_req_i,
    input  riscv151_pkg::prog_wr_t prog_i,
    output logic                   prog_ack_o,
    output logic                   retire_valid_o,
    output riscv151_pkg::retire_t  retire_o
);

    logic [IMEM_AWIDTH-1:0]  fetch_addr;
    riscv151_pkg::word_t     fetch_data, inst;
    riscv151_pkg::ctrl_t     ctrl;
    riscv151_pkg::reg_addr_t rs1, rs2, rf_waddr;
    riscv151_pkg::word_t     rdata1, rdata2, rf_wdata;
    riscv151_pkg::word_t     alu_a, alu_b, alu_result;
    riscv151_pkg::alu_op_e   alu_op;
    riscv151_pkg::br_op_e    br_op;
    logic                    alu_taken, rf_we;

    imem_loader #(.IMEM_AWIDTH(IMEM_AWIDTH)) u_imem_loader (
        .clk, .rst_n_i, .prog_req_i, .prog_i, .prog_ack_o,
        .fetch_addr_i(fetch_addr), .fetch_data_o(fetch_data));

    pipeline #(.RESET_PC(RESET_PC), .IMEM_AWIDTH(IMEM_AWIDTH)) u_pipeline (
        .clk, .rst_n_i, .core_en_i,
        .fetch_data_i(fetch_data), .ctrl_i(ctrl), .rdata1_i(rdata1), .rdata2_i(rdata2),
        .alu_result_i(alu_result), .alu_taken_i(alu_taken),
        .fetch_addr_o(fetch_addr), .inst_o(inst), .rs1_o(rs1), .rs2_o(rs2),
        .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_op_o(alu_op), .br_op_o(br_op),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .retire_valid_o, .retire_o);

    decoder u_decoder (.inst_i(inst), .ctrl_o(ctrl));

    regfile u_regfile (
        .clk, .rst_n_i, .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2));

    alu u_alu (
        .a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .br_i(br_op),
        .result_o(alu_result), .taken_o(alu_taken));

endmodule

// ==== flist.f ====
design/riscv151_pkg.sv
design/imem_loader.sv
design/decoder.sv
design/regfile.sv
design/alu.sv
design/pipeline.sv
design/riscv151_top.sv
testbench/riscv151_props.sv
testbench/tb_riscv151.sv

// ==== testbench/riscv151_props.sv ====
module riscv151_props (
    input logic                  clk,
    input logic                  rst_n_i,
    input logic                  core_en_i,
    input logic                  prog_req_i,
    input logic                  prog_ack_i,
    input logic                  retire_valid_i,
    input riscv151_pkg::retire_t retire_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0; // failed assertion tally

    // ack answers a request seen on the edge before
    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n_i)
            $rose(prog_ack_i) |-> $past(prog_req_i)) else begin
        $error("prog_ack rose with no request pending");
        fail_count++;
    end

    req_held_for_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
            $fell(prog_req_i) |-> prog_ack_i) else begin
        $error("prog_req dropped before acknowledge");
        fail_count++;
    end

    retire_known: assert property (@(posedge clk) disable iff (!rst_n_i)
            retire_valid_i |-> !$isunknown(retire_i)) else begin
        $error("retire record has unknown bits");
        fail_count++;
    end

    // idle core keeps its stages empty
    no_retire_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
            !core_en_i |-> !retire_valid_i) else begin
        $error("retire while core disabled");
        fail_count++;
    end

endmodule

// ==== testbench/tb_riscv151.sv ====
module tb_riscv151;
    timeunit 1ns;
    timeprecision 100ps;

    localparam riscv151_pkg::word_t RESET_PC    = 32'h0000_0100; // word 64, off zero on purpose
    localparam int                  IMEM_AWIDTH = 8;

    typedef struct packed {
        riscv151_pkg::word_t     inst;
        riscv151_pkg::word_t     pc;
        riscv151_pkg::reg_addr_t rd;       // zero for non-writers
        riscv151_pkg::word_t     data;
        logic                    squashed; // behind a taken branch or jal
    } entry_t;

    logic                   clk;
    logic                   rst_n_i, core_en_i, prog_req_i;
    riscv151_pkg::prog_wr_t prog_i;
    logic                   prog_ack_o, retire_valid_o;
    riscv151_pkg::retire_t  retire_o;

    entry_t prog_q[$];       // program image in memory order
    int     exp_idx     = 0; // next entry the retire port owes us
    int     cycles      = 0;
    int     cycle_limit = 0;

    riscv151_top #(.RESET_PC(RESET_PC), .IMEM_AWIDTH(IMEM_AWIDTH)) u_riscv151_top (
        .clk, .rst_n_i, .core_en_i, .prog_req_i, .prog_i,
        .prog_ack_o, .retire_valid_o, .retire_o);

    bind riscv151_top riscv151_props u_props (
        .clk(clk), .rst_n_i(rst_n_i), .core_en_i(core_en_i), .prog_req_i(prog_req_i),
        .prog_ack_i(prog_ack_o), .retire_valid_i(retire_valid_o), .retire_i(retire_o));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    task automatic check_word(input string name, input riscv151_pkg::word_t got,
                              input riscv151_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s does not match", name);
        end
    endtask

    task automatic check_reg(input string name, input riscv151_pkg::reg_addr_t got,
                             input riscv151_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got x%0d expected x%0d", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s does not match", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s does not match", name);
        end
    endtask

    // pc follows from the position in memory
    task automatic push_entry(input riscv151_pkg::word_t inst, input riscv151_pkg::reg_addr_t rd,
                              input riscv151_pkg::word_t data, input logic squashed);
        prog_q.push_back(entry_t'{inst, RESET_PC + 4 * prog_q.size(), rd, data, squashed});
    endtask

    // one four-phase write, entered and left 1 ns after a rising edge
    task automatic load_word(input riscv151_pkg::word_t addr, input riscv151_pkg::word_t data);
        int unsigned gap;
        gap = $urandom % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        prog_i.addr = addr;
        prog_i.data = data;
        prog_req_i  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!prog_ack_o);
        prog_req_i = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (prog_ack_o); // ack low again, next request allowed
    endtask

    initial begin
        void'($urandom(71));
        rst_n_i    = 1'b0;
        core_en_i  = 1'b0;
        prog_req_i = 1'b0;
        prog_i     = '0;
        push_entry(32'h0050_0093, 5'd1,  32'h0000_0005, 1'b0); // addi x1, x0, 5
        push_entry(32'hffd0_8113, 5'd2,  32'h0000_0002, 1'b0); // addi x2, x1, -3 fwd
        push_entry(32'h0020_81b3, 5'd3,  32'h0000_0007, 1'b0); // add x3, x1, x2 fwd
        push_entry(32'h4011_0233, 5'd4,  32'hffff_fffd, 1'b0); // sub x4, x2, x1
        push_entry(32'h1234_52b7, 5'd5,  32'h1234_5000, 1'b0); // lui x5, 0x12345
        push_entry(32'h6782_e293, 5'd5,  32'h1234_5678, 1'b0); // ori x5, x5, 0x678
        push_entry(32'h0042_c333, 5'd6,  32'hedcb_a985, 1'b0); // xor x6, x5, x4
        push_entry(32'h4012_5393, 5'd7,  32'hffff_fffe, 1'b0); // srai x7, x4, 1
        push_entry(32'h01c2_5413, 5'd8,  32'h0000_000f, 1'b0); // srli x8, x4, 28
        push_entry(32'h0040_9493, 5'd9,  32'h0000_0050, 1'b0); // slli x9, x1, 4
        push_entry(32'h0012_2533, 5'd10, 32'h0000_0001, 1'b0); // slt x10, x4, x1
        push_entry(32'h0012_35b3, 5'd11, 32'h0000_0000, 1'b0); // sltu x11, x4, x1
        push_entry(32'h0082_f633, 5'd12, 32'h0000_0008, 1'b0); // and x12, x5, x8
        push_entry(32'h0070_8013, 5'd0,  32'h0000_0000, 1'b0); // addi x0, x1, 7
        push_entry(32'h0010_0733, 5'd14, 32'h0000_0005, 1'b0); // add x14, x0, x1
        push_entry(32'h00e0_8463, 5'd0,  32'h0000_0000, 1'b0); // beq x1, x14, +8 taken
        push_entry(32'h0010_0793, 5'd0,  32'h0000_0000, 1'b1);
        push_entry(32'h0020_9463, 5'd0,  32'h0000_0000, 1'b0); // bne x1, x2, +8 taken
        push_entry(32'h0020_0793, 5'd0,  32'h0000_0000, 1'b1);
        push_entry(32'h0012_4463, 5'd0,  32'h0000_0000, 1'b0); // blt x4, x1, +8 signed
        push_entry(32'h0030_0793, 5'd0,  32'h0000_0000, 1'b1);
        push_entry(32'h0040_d463, 5'd0,  32'h0000_0000, 1'b0); // bge x1, x4, +8 taken
        push_entry(32'h0040_0793, 5'd0,  32'h0000_0000, 1'b1);
        push_entry(32'h0020_8463, 5'd0,  32'h0000_0000, 1'b0); // beq x1, x2 falls through
        push_entry(32'h0012_5463, 5'd0,  32'h0000_0000, 1'b0); // bge x4, x1 falls through
        push_entry(32'h0090_0793, 5'd15, 32'h0000_0009, 1'b0); // addi x15, x0, 9
        push_entry(32'h0080_086f, 5'd16, RESET_PC + 32'h6c, 1'b0); // jal x16, +8 at +0x68
        push_entry(32'h0050_0793, 5'd0,  32'h0000_0000, 1'b1);
        push_entry(32'h00f8_08b3, 5'd17, RESET_PC + 32'h75, 1'b0); // add x17, x16, x15
        push_entry(32'h0000_006f, 5'd0,  32'h0000_0000, 1'b0); // jal x0, 0 spins here
        cycle_limit = 4 * prog_q.size() + 8 * prog_q.size();
        repeat (2) @(posedge clk);
        #1 rst_n_i = 1'b1;
        check_bit("prog_ack_o", prog_ack_o, 1'b0);
        check_bit("retire_valid_o", retire_valid_o, 1'b0);
        foreach (prog_q[i]) load_word((RESET_PC >> 2) + i, prog_q[i].inst);
        core_en_i = 1'b1; // fetch starts at RESET_PC
        wait (exp_idx == prog_q.size());
        @(posedge clk);
        if (u_riscv151_top.u_props.fail_count != 0) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "%0d bound assertion failures", u_riscv151_top.u_props.fail_count);
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    // retire port, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n_i && retire_valid_o && exp_idx < prog_q.size()) begin
            while (exp_idx < prog_q.size() && prog_q[exp_idx].squashed)
                exp_idx++;
            check_word("retire_o.pc", retire_o.pc, prog_q[exp_idx].pc);
            check_reg("retire_o.rd", retire_o.rd, prog_q[exp_idx].rd);
            check_word("retire_o.data", retire_o.data, prog_q[exp_idx].data);
            exp_idx++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout after %0d cycles with %0d of %0d entries reached",
                   cycles, exp_idx, prog_q.size());
        end else if (u_riscv151_top.u_props.fail_count != 0) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "an assertion on the program port or retire port failed");
        end
    end

endmodule
